// ==== include/sya_params.svh ====
`ifndef SYA_PARAMS_SVH
`define SYA_PARAMS_SVH

// Array geometry
`define SYA_NUM_ROW     4
`define SYA_NUM_COL     4

// Signed operand and accumulator widths
`define SYA_ACT_WIDTH   8
`define SYA_WGT_WIDTH   8
`define SYA_PSUM_WIDTH  32

// Global buffer addressing
`define SYA_ADDR_WIDTH  16

// Input channel count per run
`define SYA_CHN_WIDTH   16

`endif

// ==== logic/sya_pkg.sv ====
`default_nettype none

`include "sya_params.svh"

package sya_pkg;

    // ====================
    // Controller states
    // ====================
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        FLUSH = 2'd2,
        DRAIN = 2'd3
    } sya_state_e;

    // ====================
    // Data elements and vectors
    // ====================
    typedef logic signed [`SYA_ACT_WIDTH-1:0]  act_t;
    typedef logic signed [`SYA_WGT_WIDTH-1:0]  wgt_t;
    typedef logic signed [`SYA_PSUM_WIDTH-1:0] psum_t;
    typedef logic [`SYA_ACT_WIDTH-1:0]         ofm_byte_t;

    // One activation per row, one weight per column
    typedef act_t [`SYA_NUM_ROW-1:0] act_vec_t;
    typedef wgt_t [`SYA_NUM_COL-1:0] wgt_vec_t;

    // Accumulators, indexed [row][col]
    typedef psum_t [`SYA_NUM_ROW-1:0][`SYA_NUM_COL-1:0] psum_grid_t;

    // Requantized output row, one byte per column
    typedef ofm_byte_t [`SYA_NUM_COL-1:0] ofm_row_t;

    // ====================
    // Configuration word
    // ====================
    typedef struct packed {
        logic [`SYA_ADDR_WIDTH-1:0] ofm_base;
        logic [`SYA_ADDR_WIDTH-1:0] act_base;
        logic [`SYA_ADDR_WIDTH-1:0] wgt_base;
        logic [`SYA_CHN_WIDTH-1:0]  num_chn;   // one or more
        logic [4:0]                 shift;
        ofm_byte_t                  zp;
    } sya_cfg_t;

endpackage

`default_nettype wire

// ==== logic/sya_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module sya_pe (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           clear,
    input  wire logic           step,
    input  wire sya_pkg::act_t  act_in,
    input  wire sya_pkg::wgt_t  wgt_in,
    output sya_pkg::act_t       act_out,
    output sya_pkg::wgt_t       wgt_out,
    output sya_pkg::psum_t      psum
);
    import sya_pkg::*;

    psum_t prod;

    // Signed product, sign extended into the accumulator
    assign prod = act_in * wgt_in;

    // Operand forwarding east and south
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_out <= '0;
            wgt_out <= '0;
        end else if (clear) begin
            act_out <= '0;
            wgt_out <= '0;
        end else if (step) begin
            act_out <= act_in;
            wgt_out <= wgt_in;
        end
    end

    // Output-stationary accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum <= '0;
        end else if (clear) begin
            psum <= '0;
        end else if (step) begin
            psum <= psum + prod;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sya_pe_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sya_params.svh"

module sya_pe_array (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               clear,
    input  wire logic               step,
    input  wire sya_pkg::act_vec_t  act_edge,
    input  wire sya_pkg::wgt_vec_t  wgt_edge,
    output sya_pkg::psum_grid_t     psum
);
    import sya_pkg::*;

    // Horizontal links carry activations, vertical links carry weights
    act_t act_link [`SYA_NUM_ROW][`SYA_NUM_COL+1];
    wgt_t wgt_link [`SYA_NUM_ROW+1][`SYA_NUM_COL];

    // ====================
    // West and north edges
    // ====================
    for (genvar r = 0; r < `SYA_NUM_ROW; r++) begin : g_west
        assign act_link[r][0] = act_edge[r];
    end

    for (genvar c = 0; c < `SYA_NUM_COL; c++) begin : g_north
        assign wgt_link[0][c] = wgt_edge[c];
    end

    // ====================
    // Cell grid
    // ====================
    for (genvar r = 0; r < `SYA_NUM_ROW; r++) begin : g_row
        for (genvar c = 0; c < `SYA_NUM_COL; c++) begin : g_col
            sya_pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .clear   (clear),
                .step    (step),
                .act_in  (act_link[r][c]),
                .wgt_in  (wgt_link[r][c]),
                .act_out (act_link[r][c+1]),
                .wgt_out (wgt_link[r+1][c]),
                .psum    (psum[r][c])
            );
        end
    end

endmodule

`default_nettype wire

// ==== logic/sya_feed_skew.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sya_params.svh"

module sya_feed_skew (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               clear,
    input  wire logic               beat,
    input  wire logic               step,
    input  wire sya_pkg::act_vec_t  act_rd_dat,
    input  wire sya_pkg::wgt_vec_t  wgt_rd_dat,
    output sya_pkg::act_vec_t       act_edge,
    output sya_pkg::wgt_vec_t       wgt_edge
);
    import sya_pkg::*;

    act_vec_t act_in;
    wgt_vec_t wgt_in;

    // Flush steps push zeros into the triangle
    assign act_in = beat ? act_rd_dat : '0;
    assign wgt_in = beat ? wgt_rd_dat : '0;

    // ====================
    // Activation lanes, row r delayed r steps
    // ====================
    for (genvar r = 0; r < `SYA_NUM_ROW; r++) begin : g_act_lane
        if (r == 0) begin : g_direct
            assign act_edge[r] = act_in[r];
        end else begin : g_delay
            act_t [r-1:0] pipe;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    pipe <= '0;
                end else if (clear) begin
                    pipe <= '0;
                end else if (step) begin
                    pipe[0] <= act_in[r];
                    for (int i = 1; i < r; i++) begin
                        pipe[i] <= pipe[i-1];
                    end
                end
            end

            assign act_edge[r] = pipe[r-1];
        end
    end

    // ====================
    // Weight lanes, column c delayed c steps
    // ====================
    for (genvar c = 0; c < `SYA_NUM_COL; c++) begin : g_wgt_lane
        if (c == 0) begin : g_direct
            assign wgt_edge[c] = wgt_in[c];
        end else begin : g_delay
            wgt_t [c-1:0] pipe;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    pipe <= '0;
                end else if (clear) begin
                    pipe <= '0;
                end else if (step) begin
                    pipe[0] <= wgt_in[c];
                    for (int i = 1; i < c; i++) begin
                        pipe[i] <= pipe[i-1];
                    end
                end
            end

            assign wgt_edge[c] = pipe[c-1];
        end
    end

endmodule

`default_nettype wire

// ==== logic/sya_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sya_params.svh"

module sya_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire sya_pkg::sya_cfg_t          cfg,
    input  wire logic                       cfg_vld,
    output logic                            cfg_rdy,
    output sya_pkg::sya_cfg_t               cfg_q,
    output logic [`SYA_ADDR_WIDTH-1:0]      act_rd_addr,
    output logic                            act_rd_addr_vld,
    input  wire logic                       act_rd_addr_rdy,
    output logic [`SYA_ADDR_WIDTH-1:0]      wgt_rd_addr,
    output logic                            wgt_rd_addr_vld,
    input  wire logic                       wgt_rd_addr_rdy,
    input  wire logic                       act_rd_dat_vld,
    input  wire logic                       wgt_rd_dat_vld,
    output logic                            rd_dat_rdy,
    output logic                            beat,
    output logic                            step,
    output logic                            clear,
    output logic                            drain_start,
    input  wire logic                       drain_done
);
    import sya_pkg::*;

    // Steps needed after the last beat to reach the far corner
    localparam int FLUSH_LEN = `SYA_NUM_ROW + `SYA_NUM_COL - 2;
    localparam int FLUSH_CW  = $clog2(FLUSH_LEN + 1);

    sya_state_e                 state;
    sya_state_e                 state_nxt;
    logic [`SYA_CHN_WIDTH-1:0]  addr_cnt;
    logic [`SYA_CHN_WIDTH-1:0]  beat_cnt;
    logic [FLUSH_CW-1:0]        flush_cnt;
    logic                       cfg_xfer;
    logic                       addr_xfer;
    logic                       last_beat;
    logic                       flush_last;

    assign cfg_rdy  = (state == IDLE);
    assign cfg_xfer = cfg_vld & cfg_rdy;
    assign clear    = cfg_xfer;

    // ====================
    // Read address pair
    // ====================
    assign act_rd_addr_vld = (state == LOAD) && (addr_cnt != cfg_q.num_chn);
    assign wgt_rd_addr_vld = act_rd_addr_vld;
    // Pair moves only when both sides accept
    assign addr_xfer   = act_rd_addr_vld & act_rd_addr_rdy & wgt_rd_addr_rdy;
    assign act_rd_addr = cfg_q.act_base + `SYA_ADDR_WIDTH'(addr_cnt);
    assign wgt_rd_addr = cfg_q.wgt_base + `SYA_ADDR_WIDTH'(addr_cnt);

    // ====================
    // Read data and array advance
    // ====================
    assign rd_dat_rdy = (state == LOAD) && (beat_cnt != cfg_q.num_chn);
    assign beat       = rd_dat_rdy & act_rd_dat_vld & wgt_rd_dat_vld;
    assign last_beat  = beat && (beat_cnt == cfg_q.num_chn - 1'b1);
    assign flush_last = (state == FLUSH) && (flush_cnt == FLUSH_CW'(FLUSH_LEN - 1));
    assign step       = beat | (state == FLUSH);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (cfg_xfer) state_nxt = LOAD;
            LOAD:    if (last_beat) state_nxt = FLUSH;
            FLUSH:   if (flush_last) state_nxt = DRAIN;
            DRAIN:   if (drain_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            drain_start <= 1'b0;
            cfg_q       <= '0;
        end else begin
            state       <= state_nxt;
            // High in the first DRAIN cycle only
            drain_start <= flush_last;
            if (cfg_xfer) begin
                cfg_q <= cfg;
            end
        end
    end

    // Channel counters, restarted by each new config
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt <= '0;
            beat_cnt <= '0;
        end else if (cfg_xfer) begin
            addr_cnt <= '0;
            beat_cnt <= '0;
        end else begin
            if (addr_xfer) begin
                addr_cnt <= addr_cnt + 1'b1;
            end
            if (beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush_cnt <= '0;
        end else if (state == FLUSH) begin
            flush_cnt <= flush_cnt + 1'b1;
        end else begin
            flush_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sya_ofm_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sya_params.svh"

module sya_ofm_drain (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       drain_start,
    input  wire logic [`SYA_ADDR_WIDTH-1:0] ofm_base,
    input  wire logic [4:0]                 shift,
    input  wire sya_pkg::ofm_byte_t         zp,
    input  wire sya_pkg::psum_grid_t        psum,
    output sya_pkg::ofm_row_t               ofm_wr_dat,
    output logic [`SYA_ADDR_WIDTH-1:0]      ofm_wr_addr,
    output logic                            ofm_wr_vld,
    input  wire logic                       ofm_wr_rdy,
    output logic                            drain_done
);
    import sya_pkg::*;

    localparam int ROW_CW = (`SYA_NUM_ROW > 1) ? $clog2(`SYA_NUM_ROW) : 1;
    localparam logic [ROW_CW-1:0] LAST_ROW = ROW_CW'(`SYA_NUM_ROW - 1);

    logic [ROW_CW-1:0] row_cnt;
    logic              wr_xfer;

    assign wr_xfer    = ofm_wr_vld & ofm_wr_rdy;
    assign drain_done = wr_xfer && (row_cnt == LAST_ROW);

    // ====================
    // Row sequencing
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_wr_vld  <= 1'b0;
            row_cnt     <= '0;
            ofm_wr_addr <= '0;
        end else if (drain_start) begin
            ofm_wr_vld  <= 1'b1;
            row_cnt     <= '0;
            ofm_wr_addr <= ofm_base;
        end else if (wr_xfer) begin
            // Last row written, stop
            if (row_cnt == LAST_ROW) begin
                ofm_wr_vld <= 1'b0;
            end else begin
                row_cnt     <= row_cnt + 1'b1;
                ofm_wr_addr <= ofm_wr_addr + 1'b1;
            end
        end
    end

    // ====================
    // ReLU, shift and zero point per byte
    // ====================
    always_comb begin
        psum_t acc;
        psum_t shifted;
        for (int c = 0; c < `SYA_NUM_COL; c++) begin
            acc     = psum[row_cnt][c];
            shifted = acc >> shift;
            if (acc[`SYA_PSUM_WIDTH-1]) begin
                ofm_wr_dat[c] = '0;
            end else begin
                // Wraps modulo 256
                ofm_wr_dat[c] = shifted[`SYA_ACT_WIDTH-1:0] + zp;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sya_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sya_params.svh"

module sya_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire sya_pkg::sya_cfg_t          cfg,
    input  wire logic                       cfg_vld,
    output logic                            cfg_rdy,
    output logic [`SYA_ADDR_WIDTH-1:0]      act_rd_addr,
    output logic                            act_rd_addr_vld,
    input  wire logic                       act_rd_addr_rdy,
    output logic [`SYA_ADDR_WIDTH-1:0]      wgt_rd_addr,
    output logic                            wgt_rd_addr_vld,
    input  wire logic                       wgt_rd_addr_rdy,
    input  wire sya_pkg::act_vec_t          act_rd_dat,
    input  wire logic                       act_rd_dat_vld,
    input  wire sya_pkg::wgt_vec_t          wgt_rd_dat,
    input  wire logic                       wgt_rd_dat_vld,
    output logic                            rd_dat_rdy,
    output sya_pkg::ofm_row_t               ofm_wr_dat,
    output logic [`SYA_ADDR_WIDTH-1:0]      ofm_wr_addr,
    output logic                            ofm_wr_vld,
    input  wire logic                       ofm_wr_rdy
);
    import sya_pkg::*;

    sya_cfg_t   cfg_q;
    logic       beat;
    logic       step;
    logic       clear;
    logic       drain_start;
    logic       drain_done;
    act_vec_t   act_edge;
    wgt_vec_t   wgt_edge;
    psum_grid_t psum;

    sya_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg             (cfg),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg_q           (cfg_q),
        .act_rd_addr     (act_rd_addr),
        .act_rd_addr_vld (act_rd_addr_vld),
        .act_rd_addr_rdy (act_rd_addr_rdy),
        .wgt_rd_addr     (wgt_rd_addr),
        .wgt_rd_addr_vld (wgt_rd_addr_vld),
        .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .act_rd_dat_vld  (act_rd_dat_vld),
        .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .rd_dat_rdy      (rd_dat_rdy),
        .beat            (beat),
        .step            (step),
        .clear           (clear),
        .drain_start     (drain_start),
        .drain_done      (drain_done)
    );

    sya_feed_skew u_feed_skew (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .beat       (beat),
        .step       (step),
        .act_rd_dat (act_rd_dat),
        .wgt_rd_dat (wgt_rd_dat),
        .act_edge   (act_edge),
        .wgt_edge   (wgt_edge)
    );

    sya_pe_array u_pe_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .step     (step),
        .act_edge (act_edge),
        .wgt_edge (wgt_edge),
        .psum     (psum)
    );

    sya_ofm_drain u_ofm_drain (
        .clk         (clk),
        .rst_n       (rst_n),
        .drain_start (drain_start),
        .ofm_base    (cfg_q.ofm_base),
        .shift       (cfg_q.shift),
        .zp          (cfg_q.zp),
        .psum        (psum),
        .ofm_wr_dat  (ofm_wr_dat),
        .ofm_wr_addr (ofm_wr_addr),
        .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr_rdy  (ofm_wr_rdy),
        .drain_done  (drain_done)
    );

endmodule

`default_nettype wire

// ==== testbench/sya_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sya_params.svh"

module sya_tb;
    import sya_pkg::*;

    localparam int NR = `SYA_NUM_ROW;
    localparam int NC = `SYA_NUM_COL;
    localparam int GAP_FACTOR = 16;
    localparam int NUM_TESTS = 6;

    // Per-test settings
    string       name_list  [NUM_TESTS] = '{"chn1_rand", "chn3_rand", "chn17_rand",
                                            "relu_neg", "shift_zp_wrap", "back_to_back"};
    int          chn_list   [NUM_TESTS] = '{1, 3, 17, 5, 9, 2};
    logic [4:0]  shift_list [NUM_TESTS] = '{5'd0, 5'd0, 5'd4, 5'd0, 5'd3, 5'd1};
    logic [7:0]  zp_list    [NUM_TESTS] = '{8'h00, 8'h00, 8'h00, 8'h11, 8'hf0, 8'h05};
    logic        neg_list   [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    logic [2:0]  gap_list   [NUM_TESTS] = '{3'd2, 3'd3, 3'd2, 3'd1, 3'd3, 3'd0};

    logic                       clk;
    logic                       rst_n;
    sya_cfg_t                   cfg;
    logic                       cfg_vld;
    logic                       cfg_rdy;
    logic [`SYA_ADDR_WIDTH-1:0] act_rd_addr;
    logic                       act_rd_addr_vld;
    logic                       act_rd_addr_rdy;
    logic [`SYA_ADDR_WIDTH-1:0] wgt_rd_addr;
    logic                       wgt_rd_addr_vld;
    logic                       wgt_rd_addr_rdy;
    act_vec_t                   act_rd_dat;
    logic                       act_rd_dat_vld;
    wgt_vec_t                   wgt_rd_dat;
    logic                       wgt_rd_dat_vld;
    logic                       rd_dat_rdy;
    ofm_row_t                   ofm_wr_dat;
    logic [`SYA_ADDR_WIDTH-1:0] ofm_wr_addr;
    logic                       ofm_wr_vld;
    logic                       ofm_wr_rdy;

    // Buffer contents, indexed by address
    act_vec_t    act_mem [0:65535];
    wgt_vec_t    wgt_mem [0:65535];
    logic [15:0] act_q [$];
    logic [15:0] wgt_q [$];

    logic [15:0] lfsr = 16'd6;
    logic [2:0]  gap_lvl;
    logic        neg_mode;
    string       test_name = "reset";
    sya_cfg_t    cur_cfg;
    int          addr_cnt;
    int          beat_cnt;
    int          wr_cnt;
    logic        busy;
    event        run_done;

    sya_top dut (.*);

    always #4 clk = ~clk;

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Ready or valid with a random gap, denser as gap_lvl rises
    function automatic logic rand_ready();
        return rand_bits(3) >= 32'(gap_lvl);
    endfunction

    // ReLU, shift and zero point applied to each dot product of a row
    function automatic ofm_row_t ref_row(input int r);
        ofm_row_t    row;
        int          sum;
        logic [15:0] a;
        logic [15:0] w;
        for (int c = 0; c < NC; c++) begin
            sum = 0;
            for (int k = 0; k < int'(cur_cfg.num_chn); k++) begin
                a = cur_cfg.act_base + 16'(k);
                w = cur_cfg.wgt_base + 16'(k);
                sum += int'(act_mem[a][r]) * int'(wgt_mem[w][c]);
            end
            if (sum < 0) begin
                row[c] = 8'h00;
            end else begin
                row[c] = 8'((sum >>> cur_cfg.shift) + int'(cur_cfg.zp));
            end
        end
        return row;
    endfunction

    task automatic stop_failed();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic value_fail(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        stop_failed();
    endtask

    task automatic error_stop(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        stop_failed();
    endtask

    // ====================
    // Concurrent checks
    // ====================
    assert property (@(posedge clk) !rst_n |-> cfg_rdy && !act_rd_addr_vld
                     && !wgt_rd_addr_vld && !rd_dat_rdy && !ofm_wr_vld)
        else error_stop("outputs not idle during reset");

    assert property (@(posedge clk) disable iff (!rst_n) act_rd_addr_vld == wgt_rd_addr_vld)
        else error_stop("address valids differ");

    assert property (@(posedge clk) disable iff (!rst_n)
                     act_rd_addr_vld && !(act_rd_addr_rdy && wgt_rd_addr_rdy) |=>
                     act_rd_addr_vld && $stable(act_rd_addr) && $stable(wgt_rd_addr))
        else error_stop("read address pair changed before its transfer");

    assert property (@(posedge clk) disable iff (!rst_n)
                     ofm_wr_vld && !ofm_wr_rdy |=>
                     ofm_wr_vld && $stable(ofm_wr_dat) && $stable(ofm_wr_addr))
        else error_stop("output write changed under back-pressure");

    // ====================
    // Buffer model
    // ====================
    always @(posedge clk) begin
        if (rst_n) begin
            if (act_rd_addr_vld && act_rd_addr_rdy && wgt_rd_addr_rdy) begin
                act_q.push_back(act_rd_addr);
                wgt_q.push_back(wgt_rd_addr);
            end
            // Next beat once the current one is consumed
            if (!act_rd_dat_vld || rd_dat_rdy) begin
                if (act_q.size() > 0 && rand_ready()) begin
                    act_rd_dat     <= act_mem[act_q.pop_front()];
                    wgt_rd_dat     <= wgt_mem[wgt_q.pop_front()];
                    act_rd_dat_vld <= 1'b1;
                    wgt_rd_dat_vld <= 1'b1;
                end else begin
                    act_rd_dat_vld <= 1'b0;
                    wgt_rd_dat_vld <= 1'b0;
                end
            end
            act_rd_addr_rdy <= rand_ready();
            wgt_rd_addr_rdy <= rand_ready();
            ofm_wr_rdy      <= rand_ready();
        end
    end

    // ====================
    // Transfer monitor
    // ====================
    always @(posedge clk) begin : monitor
        logic [15:0] exp_addr;
        ofm_row_t    exp_row;
        if (rst_n) begin
            if (busy) begin
                assert (!cfg_rdy) else value_fail("cfg_rdy during run", 0, cfg_rdy);
            end else begin
                // Between runs the engine waits for a config
                assert (cfg_rdy && !act_rd_addr_vld && !wgt_rd_addr_vld && !rd_dat_rdy
                        && !ofm_wr_vld)
                    else error_stop("engine not idle between runs");
            end
            if (cfg_vld && cfg_rdy) begin
                cur_cfg  = cfg;
                addr_cnt = 0;
                beat_cnt = 0;
                wr_cnt   = 0;
                busy     = 1'b1;
            end
            if (act_rd_addr_vld && act_rd_addr_rdy && wgt_rd_addr_rdy) begin
                exp_addr = cur_cfg.act_base + 16'(addr_cnt);
                assert (act_rd_addr == exp_addr)
                    else value_fail("act_rd_addr", exp_addr, act_rd_addr);
                exp_addr = cur_cfg.wgt_base + 16'(addr_cnt);
                assert (wgt_rd_addr == exp_addr)
                    else value_fail("wgt_rd_addr", exp_addr, wgt_rd_addr);
                addr_cnt++;
                assert (addr_cnt <= int'(cur_cfg.num_chn))
                    else error_stop("more address pairs than channels");
            end
            if (act_rd_dat_vld && wgt_rd_dat_vld && rd_dat_rdy) begin
                beat_cnt++;
                assert (beat_cnt <= int'(cur_cfg.num_chn))
                    else error_stop("more data beats than channels");
            end
            if (ofm_wr_vld && ofm_wr_rdy) begin
                assert (busy) else error_stop("output write outside a run");
                exp_addr = cur_cfg.ofm_base + 16'(wr_cnt);
                exp_row  = ref_row(wr_cnt);
                assert (ofm_wr_addr == exp_addr)
                    else value_fail("ofm_wr_addr", exp_addr, ofm_wr_addr);
                if (neg_mode) begin
                    assert (ofm_wr_dat == '0) else value_fail("relu zero", 0, ofm_wr_dat);
                end
                assert (ofm_wr_dat == exp_row) else value_fail("ofm_wr_dat", exp_row, ofm_wr_dat);
                wr_cnt++;
                if (wr_cnt == NR) begin
                    busy = 1'b0;
                    -> run_done;
                end
            end
        end
    end

    // One full run: fill memories, send the config, wait for the last write
    task automatic run_test(input int t);
        sya_cfg_t    c;
        logic [15:0] a;
        test_name = name_list[t];
        gap_lvl   = gap_list[t];
        neg_mode  = neg_list[t];
        c.ofm_base = rand_bits(16);
        c.act_base = rand_bits(16);
        c.wgt_base = rand_bits(16);
        c.num_chn  = 16'(chn_list[t]);
        c.shift    = shift_list[t];
        c.zp       = zp_list[t];
        for (int k = 0; k < chn_list[t]; k++) begin
            a = c.act_base + 16'(k);
            act_mem[a] = rand_bits(32);
            // Positive activations against negative weights
            if (neg_mode) begin
                act_mem[a] = (act_mem[a] & 32'h7f7f7f7f) | 32'h01010101;
            end
            a = c.wgt_base + 16'(k);
            wgt_mem[a] = neg_mode ? (rand_bits(32) | 32'h80808080) : rand_bits(32);
        end
        @(posedge clk);
        cfg     <= c;
        cfg_vld <= 1'b1;
        @(posedge clk);
        while (!cfg_rdy) begin
            @(posedge clk);
        end
        cfg_vld <= 1'b0;
        @(run_done);
        assert (addr_cnt == chn_list[t]) else value_fail("address pairs", chn_list[t], addr_cnt);
        assert (beat_cnt == chn_list[t]) else value_fail("data beats", chn_list[t], beat_cnt);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 20;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycles += (chn_list[t] + NR + NC + NR) * GAP_FACTOR;
        end
        #(cycles * 8);
        error_stop("timeout, the tests did not finish in the expected time");
    end

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        cfg             = '0;
        cfg_vld         = 1'b0;
        act_rd_addr_rdy = 1'b0;
        wgt_rd_addr_rdy = 1'b0;
        act_rd_dat      = '0;
        act_rd_dat_vld  = 1'b0;
        wgt_rd_dat      = '0;
        wgt_rd_dat_vld  = 1'b0;
        ofm_wr_rdy      = 1'b0;
        gap_lvl         = 3'd0;
        neg_mode        = 1'b0;
        busy            = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        assert (cfg_rdy && !act_rd_addr_vld && !rd_dat_rdy && !ofm_wr_vld)
            else error_stop("outputs not idle after reset");
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        // Idle cycle after the last write
        repeat (2) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sya.f ====
+incdir+include
logic/sya_pkg.sv
logic/sya_pe.sv
logic/sya_pe_array.sv
logic/sya_feed_skew.sv
logic/sya_ctrl.sv
logic/sya_ofm_drain.sv
logic/sya_top.sv
testbench/sya_tb.sv

// ==== Bender.yml ====
package:
  name: sya

export_include_dirs:
  - include

sources:
  - logic/sya_pkg.sv
  - logic/sya_pe.sv
  - logic/sya_pe_array.sv
  - logic/sya_feed_skew.sv
  - logic/sya_ctrl.sv
  - logic/sya_ofm_drain.sv
  - logic/sya_top.sv
  - target: test
    files:
      - testbench/sya_tb.sv
